// ==== common/rob_config.svh ====
////////////////////////////////////////////////////////////////////////////
// sizing macros for the reorder buffer and the committed register file
// include wherever a depth, a count or a width is needed
////////////////////////////////////////////////////////////////////////////

`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// reorder buffer depth, must be a power of two
`define ROB_SZ 8

// log2 of ROB_SZ, keep in step with the depth
`define ROB_TAG_W 3

// architectural register file
`define REG_COUNT 32

// log2 of REG_COUNT
`define REG_IDX_W 5

// result width on the completion and retire paths
`define DATA_W 32

`endif

// ==== common/rob_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// shared types for the commit back end
// referenced by scoped name, e.g. rob_pkg::rob_tag_t
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "rob_config.svh"

package rob_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // vector types
    ////////////////////////////////////////////////////////////////////////////

    // entry index, also the tag handed back to dispatch
    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

    // architectural destination register
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    // result value
    typedef logic [`DATA_W-1:0] data_t;

    ////////////////////////////////////////////////////////////////////////////
    // buffer entry
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        // slot holds an in-flight instruction
        logic     valid;
        // result has come back on the completion bus
        logic     complete;
        // instruction writes a register at retire
        logic     has_dest;
        reg_idx_t dest_reg;
        logic     is_branch;
        // set by completion, acted on at retire
        logic     mispredict;
        data_t    value;
    } rob_entry_t;

endpackage

`default_nettype wire

// ==== common/completion_if.sv ====
////////////////////////////////////////////////////////////////////////////
// completion bus, one result per cycle from execution into the ROB
// no ready, a result with valid high is taken at that edge
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

interface completion_if;

    // result present this cycle
    logic              valid;
    // entry the result belongs to
    rob_pkg::rob_tag_t tag;
    rob_pkg::data_t    value;
    // branch resolved against its prediction
    logic              mispredict;

    // top level side, fed from plain ports
    modport source (
        output valid,
        output tag,
        output value,
        output mispredict
    );

    // reorder buffer side
    modport sink (
        input valid,
        input tag,
        input value,
        input mispredict
    );

endinterface

`default_nettype wire

// ==== common/retire_if.sv ====
////////////////////////////////////////////////////////////////////////////
// retire path, the oldest complete entry going to the register file
// no ready, the register file takes every retire
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

interface retire_if;

    // head entry valid and complete
    logic              valid;
    // write the register file only when set
    logic              has_dest;
    rob_pkg::reg_idx_t dest_reg;
    rob_pkg::data_t    value;

    // reorder buffer side
    modport source (
        output valid,
        output has_dest,
        output dest_reg,
        output value
    );

    // register file side
    modport sink (
        input valid,
        input has_dest,
        input dest_reg,
        input value
    );

endinterface

`default_nettype wire

// ==== rob/rob.sv ====
////////////////////////////////////////////////////////////////////////////
// reorder buffer: allocate at tail, mark on completion, retire from head
// a mispredicted branch squashes everything younger as it retires
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "rob_config.svh"

module rob (
    input  wire logic              clock,
    input  wire logic              reset,
    // dispatch, valid/ready
    input  wire logic              dispatch_valid,
    input  wire logic              dispatch_has_dest,
    input  wire rob_pkg::reg_idx_t dispatch_dest_reg,
    input  wire logic              dispatch_is_branch,
    output logic                   dispatch_ready,
    output rob_pkg::rob_tag_t      dispatch_tag,
    // status
    output logic                   rob_empty,
    output logic                   flush,
    // tag of the retiring entry, beside the retire interface
    output rob_pkg::rob_tag_t      retire_tag,
    completion_if.sink             complete,
    retire_if.source               retire
);

    // count value when every slot is taken
    localparam logic [`ROB_TAG_W:0] FULL_COUNT = `ROB_SZ;

    ////////////////////////////////////////////////////////////////////////////
    // state
    ////////////////////////////////////////////////////////////////////////////

    rob_pkg::rob_entry_t rob_mem [`ROB_SZ];
    // oldest in-flight entry
    rob_pkg::rob_tag_t   head;
    // next slot to allocate
    rob_pkg::rob_tag_t   tail;
    // one bit wider than a tag, tells full from empty
    logic [`ROB_TAG_W:0] count;

    rob_pkg::rob_entry_t head_entry;
    rob_pkg::rob_entry_t new_entry;
    rob_pkg::rob_tag_t   head_next;
    logic                full;
    logic                retire_fire;
    logic                dispatch_fire;
    logic                complete_hit;

    ////////////////////////////////////////////////////////////////////////////
    // combinational view of the buffer
    ////////////////////////////////////////////////////////////////////////////

    assign head_entry = rob_mem[head];
    // wraps on its own, depth is a power of two
    assign head_next  = head + rob_pkg::rob_tag_t'(1);

    assign full      = (count == FULL_COUNT);
    assign rob_empty = (count == '0);

    // retire straight from state, head advances at the next edge
    assign retire_fire = head_entry.valid && head_entry.complete;
    assign flush       = retire_fire && head_entry.mispredict;

    assign retire.valid    = retire_fire;
    assign retire.has_dest = head_entry.has_dest;
    assign retire.dest_reg = head_entry.dest_reg;
    assign retire.value    = head_entry.value;
    assign retire_tag      = head;

    // no dispatch while full or while squashing
    assign dispatch_ready = !full && !flush;
    assign dispatch_tag   = tail;
    assign dispatch_fire  = dispatch_valid && dispatch_ready;

    // results for empty slots are dropped
    assign complete_hit = complete.valid && rob_mem[complete.tag].valid;

    // fresh entry written at the tail
    always_comb begin
        new_entry            = '0;
        new_entry.valid      = 1'b1;
        new_entry.has_dest   = dispatch_has_dest;
        new_entry.dest_reg   = dispatch_dest_reg;
        new_entry.is_branch  = dispatch_is_branch;
    end

    ////////////////////////////////////////////////////////////////////////////
    // buffer update
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `ROB_SZ; i++) begin
                rob_mem[i] <= '0;
            end
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            // precise recovery, the branch retires and all younger go away
            for (int i = 0; i < `ROB_SZ; i++) begin
                rob_mem[i] <= '0;
            end
            // restart just past the branch
            head  <= head_next;
            tail  <= head_next;
            count <= '0;
        end else begin
            // completion first, so a retire clear below wins on the head slot
            if (complete_hit) begin
                rob_mem[complete.tag].complete   <= 1'b1;
                rob_mem[complete.tag].value      <= complete.value;
                rob_mem[complete.tag].mispredict <= complete.mispredict;
            end

            // retire frees the head slot
            if (retire_fire) begin
                rob_mem[head] <= '0;
                head          <= head_next;
            end

            // never the same slot as retire, tail only meets a valid head when full
            if (dispatch_fire) begin
                rob_mem[tail] <= new_entry;
                tail          <= tail + rob_pkg::rob_tag_t'(1);
            end

            // occupancy
            case ({dispatch_fire, retire_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/arch_reg_file.sv ====
////////////////////////////////////////////////////////////////////////////
// committed register file, written only by retire
// one combinational read port, register 0 keeps its reset value of zero
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "rob_config.svh"

module arch_reg_file (
    input  wire logic              clock,
    input  wire logic              reset,
    retire_if.sink                 retire,
    input  wire rob_pkg::reg_idx_t read_reg,
    output rob_pkg::data_t         read_value
);

    rob_pkg::data_t regs [`REG_COUNT];
    logic           write_en;

    // register 0 never takes a write
    assign write_en = retire.valid && retire.has_dest && (retire.dest_reg != '0);

    // committed state, all zero out of reset
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[retire.dest_reg] <= retire.value;
        end
    end

    // new value visible the cycle after the retire edge
    assign read_value = regs[read_reg];

endmodule

`default_nettype wire

// ==== verilog/rob_top.sv ====
////////////////////////////////////////////////////////////////////////////
// commit back end top level, plain ports onto the two internal buses
// holds the reorder buffer and the committed register file
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module rob_top (
    input  wire logic              clock,
    input  wire logic              reset,
    // dispatch
    input  wire logic              dispatch_valid,
    input  wire logic              dispatch_has_dest,
    input  wire rob_pkg::reg_idx_t dispatch_dest_reg,
    input  wire logic              dispatch_is_branch,
    output logic                   dispatch_ready,
    output rob_pkg::rob_tag_t      dispatch_tag,
    // completion bus
    input  wire logic              complete_valid,
    input  wire rob_pkg::rob_tag_t complete_tag,
    input  wire rob_pkg::data_t    complete_value,
    input  wire logic              complete_mispredict,
    // retire, observed
    output logic                   retire_valid,
    output rob_pkg::rob_tag_t      retire_tag,
    output logic                   retire_has_dest,
    output rob_pkg::reg_idx_t      retire_dest_reg,
    output rob_pkg::data_t         retire_value,
    // status
    output logic                   flush,
    output logic                   rob_empty,
    // register file read
    input  wire rob_pkg::reg_idx_t read_reg,
    output rob_pkg::data_t         read_value
);

    completion_if complete_bus ();
    retire_if     retire_bus ();

    // completion ports onto the bus
    assign complete_bus.valid      = complete_valid;
    assign complete_bus.tag        = complete_tag;
    assign complete_bus.value      = complete_value;
    assign complete_bus.mispredict = complete_mispredict;

    // retire bus brought out for observation
    assign retire_valid    = retire_bus.valid;
    assign retire_has_dest = retire_bus.has_dest;
    assign retire_dest_reg = retire_bus.dest_reg;
    assign retire_value    = retire_bus.value;

    rob rob_i (
        .clock              (clock),
        .reset              (reset),
        .dispatch_valid     (dispatch_valid),
        .dispatch_has_dest  (dispatch_has_dest),
        .dispatch_dest_reg  (dispatch_dest_reg),
        .dispatch_is_branch (dispatch_is_branch),
        .dispatch_ready     (dispatch_ready),
        .dispatch_tag       (dispatch_tag),
        .rob_empty          (rob_empty),
        .flush              (flush),
        .retire_tag         (retire_tag),
        .complete           (complete_bus.sink),
        .retire             (retire_bus.source)
    );

    arch_reg_file arch_reg_file_i (
        .clock      (clock),
        .reset      (reset),
        .retire     (retire_bus.sink),
        .read_reg   (read_reg),
        .read_value (read_value)
    );

endmodule

`default_nettype wire

// ==== verification/rob_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for rob_top, random dispatch and completion checked against
// a queue model of the ROB and a shadow register file
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "rob_config.svh"

module rob_tb;

    localparam int RANDOM_CYCLES  = 3000;
    // directed phases, drain and sweeps stay well under the extra 1000
    localparam int TIMEOUT_CYCLES = RANDOM_CYCLES + 1000;

    logic              clock;
    logic              reset;
    logic              dispatch_valid;
    logic              dispatch_has_dest;
    rob_pkg::reg_idx_t dispatch_dest_reg;
    logic              dispatch_is_branch;
    logic              dispatch_ready;
    rob_pkg::rob_tag_t dispatch_tag;
    logic              complete_valid;
    rob_pkg::rob_tag_t complete_tag;
    rob_pkg::data_t    complete_value;
    logic              complete_mispredict;
    logic              retire_valid;
    rob_pkg::rob_tag_t retire_tag;
    logic              retire_has_dest;
    rob_pkg::reg_idx_t retire_dest_reg;
    rob_pkg::data_t    retire_value;
    logic              flush;
    logic              rob_empty;
    rob_pkg::reg_idx_t read_reg;
    rob_pkg::data_t    read_value;

    ////////////////////////////////////////////////////////////////////////////
    // model state, program order, index 0 is the head
    ////////////////////////////////////////////////////////////////////////////

    rob_pkg::rob_entry_t model_q [$];
    rob_pkg::rob_tag_t   head_tag;
    rob_pkg::rob_tag_t   next_tag;
    rob_pkg::data_t      shadow [`REG_COUNT];
    // model view of the current cycle
    logic                cur_rv;
    logic                cur_flush;
    logic                cur_ready;
    // dispatch request still waiting for ready
    logic                pending;
    integer              seed;
    int                  cycle_count = 0;

    rob_top rob_top_i (.*);

    initial clock = 1'b0;
    always #10 clock = ~clock;

    // hang guard
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("run hung, no end after %0d cycles", TIMEOUT_CYCLES);
            stop_with_failure();
        end
    end

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_tag(input string name, input rob_pkg::rob_tag_t exp,
                             input rob_pkg::rob_tag_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_reg(input string name, input rob_pkg::reg_idx_t exp,
                             input rob_pkg::reg_idx_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_data(input string name, input rob_pkg::data_t exp,
                              input rob_pkg::data_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    function automatic int unsigned rand_below(input int unsigned limit);
        int unsigned r;
        r = $random(seed);
        return r % limit;
    endfunction

    // random in-flight entry still waiting for its result, -1 if none
    function automatic int random_incomplete();
        int cand [$];
        for (int i = 0; i < model_q.size(); i++) begin
            if (!model_q[i].complete) begin
                cand.push_back(i);
            end
        end
        if (cand.size() == 0) begin
            return -1;
        end
        return cand[rand_below(cand.size())];
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // per cycle check and model step
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_outputs();
        cur_rv    = (model_q.size() != 0) && model_q[0].complete;
        cur_flush = cur_rv && model_q[0].mispredict;
        cur_ready = (model_q.size() < `ROB_SZ) && !cur_flush;
        check_bit("retire_valid", cur_rv, retire_valid);
        check_bit("flush", cur_flush, flush);
        check_bit("dispatch_ready", cur_ready, dispatch_ready);
        check_bit("rob_empty", model_q.size() == 0, rob_empty);
        check_tag("dispatch_tag", next_tag, dispatch_tag);
        if (cur_rv) begin
            check_tag("retire_tag", head_tag, retire_tag);
            check_bit("retire_has_dest", model_q[0].has_dest, retire_has_dest);
            check_reg("retire_dest_reg", model_q[0].dest_reg, retire_dest_reg);
            check_data("retire_value", model_q[0].value, retire_value);
        end
        // read_reg was set a cycle ago, the last retire edge is in between
        check_data("read_value", shadow[read_reg], read_value);
    endtask

    task automatic advance_model(input logic cv, input int c_idx,
                                 input rob_pkg::data_t cval, input logic cmis);
        rob_pkg::rob_entry_t e;
        pending = dispatch_valid && !cur_ready;
        if (cur_rv && model_q[0].has_dest && model_q[0].dest_reg != '0) begin
            shadow[model_q[0].dest_reg] = model_q[0].value;
        end
        if (cur_flush) begin
            // squash everything younger, restart past the branch
            model_q.delete();
            head_tag = head_tag + rob_pkg::rob_tag_t'(1);
            next_tag = head_tag;
        end else begin
            if (cv) begin
                e            = model_q[c_idx];
                e.complete   = 1'b1;
                e.value      = cval;
                e.mispredict = cmis;
                model_q[c_idx] = e;
            end
            if (cur_rv) begin
                e        = model_q.pop_front();
                head_tag = head_tag + rob_pkg::rob_tag_t'(1);
            end
            if (dispatch_valid && cur_ready) begin
                e           = '0;
                e.valid     = 1'b1;
                e.has_dest  = dispatch_has_dest;
                e.dest_reg  = dispatch_dest_reg;
                e.is_branch = dispatch_is_branch;
                model_q.push_back(e);
                next_tag = next_tag + rob_pkg::rob_tag_t'(1);
            end
        end
    endtask

    // check at the falling edge, then drive the next inputs
    task automatic run_cycle(input logic dv, input logic hd, input rob_pkg::reg_idx_t dr,
                             input logic br, input logic cv, input int c_idx,
                             input rob_pkg::data_t cval, input logic cmis,
                             input rob_pkg::reg_idx_t rr);
        @(negedge clock);
        check_outputs();
        dispatch_valid      = dv;
        dispatch_has_dest   = hd;
        dispatch_dest_reg   = dr;
        dispatch_is_branch  = br;
        complete_valid      = cv;
        complete_tag        = head_tag + rob_pkg::rob_tag_t'(c_idx);
        complete_value      = cval;
        complete_mispredict = cmis;
        read_reg            = rr;
        advance_model(cv, c_idx, cval, cmis);
    endtask

    task automatic idle_cycle(input rob_pkg::reg_idx_t rr);
        run_cycle(1'b0, 1'b0, '0, 1'b0, 1'b0, 0, '0, 1'b0, rr);
    endtask

    // complete whatever is left until the buffer is empty
    task automatic drain();
        int idx;
        while (model_q.size() != 0 || pending) begin
            idx = random_incomplete();
            run_cycle(pending, dispatch_has_dest, dispatch_dest_reg, dispatch_is_branch,
                      idx >= 0, idx, $random(seed), 1'b0,
                      rob_pkg::reg_idx_t'(rand_below(`REG_COUNT)));
        end
    endtask

    task automatic sweep_regs();
        for (int r = 0; r < `REG_COUNT; r++) begin
            idle_cycle(rob_pkg::reg_idx_t'(r));
        end
        // checks the last register
        idle_cycle('0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic              dv;
        logic              hd;
        logic              br;
        logic              cv;
        logic              cmis;
        int                c_idx;
        rob_pkg::reg_idx_t dr;
        rob_pkg::rob_tag_t branch_tag;

        seed = 46168;
        reset = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_has_dest = 1'b0;
        dispatch_dest_reg = '0;
        dispatch_is_branch = 1'b0;
        complete_valid = 1'b0;
        complete_tag = '0;
        complete_value = '0;
        complete_mispredict = 1'b0;
        read_reg = '0;
        head_tag = '0;
        next_tag = '0;
        pending = 1'b0;
        for (int r = 0; r < `REG_COUNT; r++) begin
            shadow[r] = '0;
        end
        repeat (16) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // reset state, every register reads zero
        sweep_regs();

        // back-pressure, fill with no completions then hold a request
        for (int i = 0; i < `ROB_SZ; i++) begin
            run_cycle(1'b1, 1'b1, rob_pkg::reg_idx_t'(i + 1), 1'b0, 1'b0, 0, '0, 1'b0, '0);
        end
        repeat (3) run_cycle(1'b1, 1'b1, 5'd20, 1'b0, 1'b0, 0, '0, 1'b0, '0);
        check_bit("dispatch_ready", 1'b0, dispatch_ready);
        run_cycle(1'b1, 1'b1, 5'd20, 1'b0, 1'b1, 0, 32'h1234_5678, 1'b0, 5'd1);
        drain();

        // mispredicted branch with three younger entries behind it
        branch_tag = next_tag;
        run_cycle(1'b1, 1'b0, '0, 1'b1, 1'b0, 0, '0, 1'b0, '0);
        for (int i = 0; i < 3; i++) begin
            run_cycle(1'b1, 1'b1, rob_pkg::reg_idx_t'(i + 3), 1'b0, 1'b0, 0, '0, 1'b0, '0);
        end
        for (int i = 1; i < 4; i++) begin
            run_cycle(1'b0, 1'b0, '0, 1'b0, 1'b1, i, $random(seed), 1'b0, '0);
        end
        run_cycle(1'b0, 1'b0, '0, 1'b0, 1'b1, 0, '0, 1'b1, '0);
        drain();
        idle_cycle('0);
        check_bit("rob_empty", 1'b1, rob_empty);
        check_tag("dispatch_tag", branch_tag + rob_pkg::rob_tag_t'(1), dispatch_tag);

        // random traffic, a waiting request keeps its fields
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            if (pending) begin
                dv = 1'b1;
                hd = dispatch_has_dest;
                dr = dispatch_dest_reg;
                br = dispatch_is_branch;
            end else begin
                dv = rand_below(100) < 60;
                hd = rand_below(2) == 1;
                dr = rob_pkg::reg_idx_t'(rand_below(`REG_COUNT));
                br = rand_below(100) < 25;
            end
            c_idx = random_incomplete();
            cv    = (c_idx >= 0) && (rand_below(100) < 70);
            cmis  = 1'b0;
            if (cv && model_q[c_idx].is_branch) begin
                cmis = rand_below(100) < 15;
            end
            run_cycle(dv, hd, dr, br, cv, c_idx, $random(seed), cmis,
                      rob_pkg::reg_idx_t'(rand_below(`REG_COUNT)));
        end

        // settle and sweep the committed state
        drain();
        sweep_regs();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+common
common/rob_pkg.sv
common/completion_if.sv
common/retire_if.sv
rob/rob.sv
verilog/arch_reg_file.sv
verilog/rob_top.sv
verification/rob_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the ROB testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f vlog.f --top-module rob_tb -Mdir obj_dir

# a failing run exits non-zero, the output search decides the result
output=$(./obj_dir/Vrob_tb || true)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1
